// ==== build.f ====
hdl/rs_pkg.sv
hdl/cdb_if.sv
hdl/operand_snoop.sv
hdl/rs_entry.sv
hdl/issue_register.sv
hdl/reservation_station.sv
dv/tb_reservation_station.sv

// ==== dv/tb_reservation_station.sv ====
`timescale 1ns/100ps

module tb_reservation_station
    import rs_pkg::*;
();

    localparam int data_width = 32;
    localparam int timeout    = 20;
    localparam int num_steps  = 6;
    localparam int num_rows   = 7;

    // Bit s of every mask applies s cycles after the dispatch cycle
    typedef struct packed {
        tag_t       a_tag;
        tag_t       b_tag;
        rob_idx_t   rob;
        rob_idx_t   head;
        logic [5:0] strobe0;
        logic [5:0] strobe1;
        logic [5:0] strobe2;
        logic [5:0] rdy;
        logic [5:0] flush;
        rob_dist_t  md;
        logic       exp_issue;
        int         exp_lat;
    } row_t;

    logic                  clk = 1'b0;
    logic                  reset;
    logic                  dispatch_valid;
    logic                  dispatch_ready;
    ctrl_t                 ctrl;
    logic [31:0]           pc;
    phys_reg_t             rd_phys;
    rob_idx_t              rob_idx;
    tag_t                  operand_a_tag;
    logic [data_width-1:0] operand_a_data;
    tag_t                  operand_b_tag;
    logic [data_width-1:0] operand_b_data;
    logic [num_cdb-1:0]    cdb_valid;
    logic [data_width-1:0] cdb_data [num_cdb];
    logic                  eager_flush;
    rob_dist_t             mispredicted_distance;
    rob_idx_t              rob_head;
    logic                  issue_ready;
    logic                  issue_valid;
    ctrl_t                 issue_ctrl;
    logic [31:0]           issue_pc;
    phys_reg_t             issue_rd_phys;
    logic [data_width-1:0] issue_data_a;
    logic [data_width-1:0] issue_data_b;

    // Reference model state and the outputs it predicts
    logic                  m_occ;
    tag_t                  m_a_tag;
    tag_t                  m_b_tag;
    logic [data_width-1:0] m_a_data;
    logic [data_width-1:0] m_b_data;
    rs_payload_t           m_payload;
    logic                  exp_valid;
    rs_payload_t           exp_payload;
    logic [data_width-1:0] exp_a;
    logic [data_width-1:0] exp_b;

    integer seed;
    row_t   table_rows [num_rows];

    reservation_station #(.data_width(data_width)) reservation_station_i (.*);

    always #4 clk = ~clk;

    // ====================
    // Compare tasks
    // ====================

    task automatic fail_run(input string what);
        $display("%s", what);
        $display("RESULT: FAIL");
        $fatal(1);
    endtask

    task automatic check_payload(input rs_payload_t got, input rs_payload_t exp,
                                 input string what);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_data(input logic [data_width-1:0] got,
                              input logic [data_width-1:0] exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %h expected %h", $time, what, got, exp));
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %b expected %b", $time, what, got, exp));
        end
    endtask

    task automatic check_count(input int got, input int exp, input string what);
        if (got != exp) begin
            fail_run($sformatf("Mismatch at %0t: %s got %0d expected %0d", $time, what, got, exp));
        end
    endtask

    // ====================
    // Reference model
    // ====================

    // Operand value as seen this cycle where a strobe on the tagged channel wins
    task automatic snoop(input tag_t t, input logic [data_width-1:0] stored,
                         output logic hit, output logic [data_width-1:0] val);
        hit = (t == tag_ready);
        val = stored;
        if (t != tag_ready && cdb_valid[t]) begin
            hit = 1'b1;
            val = cdb_data[t];
        end
    endtask

    // Advances the model over the coming rising edge with the inputs now driven
    task automatic model_edge();
        logic                  a_hit;
        logic                  b_hit;
        logic [data_width-1:0] a_val;
        logic [data_width-1:0] b_val;
        rob_dist_t             age;
        snoop(m_a_tag, m_a_data, a_hit, a_val);
        snoop(m_b_tag, m_b_data, b_hit, b_val);
        age = rob_dist_t'((int'(m_payload.rob_idx) - int'(rob_head) + rob_depth) % rob_depth);
        exp_valid = 1'b0;
        if (dispatch_valid && !m_occ) begin
            if (operand_a_tag == tag_ready && operand_b_tag == tag_ready && issue_ready) begin
                exp_valid   = 1'b1;
                exp_payload = '{ctrl: ctrl, pc: pc, rd_phys: rd_phys, rob_idx: rob_idx};
                exp_a       = operand_a_data;
                exp_b       = operand_b_data;
            end else begin
                m_occ     = 1'b1;
                m_payload = '{ctrl: ctrl, pc: pc, rd_phys: rd_phys, rob_idx: rob_idx};
                m_a_tag   = operand_a_tag;
                m_b_tag   = operand_b_tag;
                m_a_data  = operand_a_data;
                m_b_data  = operand_b_data;
            end
        end else if (m_occ) begin
            if (eager_flush && age > mispredicted_distance) begin
                m_occ = 1'b0;
            end else if (a_hit && b_hit && issue_ready) begin
                exp_valid   = 1'b1;
                exp_payload = m_payload;
                exp_a       = a_val;
                exp_b       = b_val;
                m_occ       = 1'b0;
            end else begin
                if (a_hit) begin
                    m_a_tag  = tag_ready;
                    m_a_data = a_val;
                end
                if (b_hit) begin
                    m_b_tag  = tag_ready;
                    m_b_data = b_val;
                end
            end
        end
    endtask

    // ====================
    // Stimulus
    // ====================

    task automatic drive_step(input row_t r, input int s, input logic disp);
        logic [2:0] idx;
        idx            = 3'(s);
        dispatch_valid = disp;
        cdb_data[0]    = $random(seed);
        cdb_data[1]    = $random(seed);
        cdb_data[2]    = $random(seed);
        if (s < num_steps) begin
            cdb_valid   = {r.strobe2[idx], r.strobe1[idx], r.strobe0[idx]};
            issue_ready = r.rdy[idx];
            eager_flush = r.flush[idx];
        end else begin
            // The unit keeps its last readiness once the scripted steps are over
            cdb_valid   = '0;
            issue_ready = r.rdy[num_steps-1];
            eager_flush = 1'b0;
        end
        mispredicted_distance = r.md;
        rob_head              = r.head;
    endtask

    // One clock of DUT and model with outputs checked 1 ns after the edge
    task automatic step_cycle();
        rs_payload_t got;
        model_edge();
        @(posedge clk);
        #1;
        check_flag(issue_valid, exp_valid, "issue_valid");
        check_flag(dispatch_ready, !m_occ, "dispatch_ready");
        if (exp_valid) begin
            // ROB index is not brought out on the issue side
            got = '{ctrl: issue_ctrl, pc: issue_pc, rd_phys: issue_rd_phys,
                    rob_idx: exp_payload.rob_idx};
            check_payload(got, exp_payload, "issued payload");
            check_data(issue_data_a, exp_a, "issued operand A");
            check_data(issue_data_b, exp_b, "issued operand B");
        end
    endtask

    task automatic run_row(input row_t r, input int n);
        int   wait_cycles;
        int   c;
        logic seen;
        wait_cycles = 0;
        while (!dispatch_ready) begin
            if (wait_cycles == timeout) begin
                fail_run($sformatf("Row %0d: dispatch_ready never came back high", n));
            end
            drive_step(r, num_steps, 1'b0);
            step_cycle();
            wait_cycles++;
        end
        ctrl           = ctrl_t'($random(seed));
        pc             = $random(seed);
        rd_phys        = phys_reg_t'($random(seed));
        rob_idx        = r.rob;
        operand_a_tag  = r.a_tag;
        operand_b_tag  = r.b_tag;
        operand_a_data = $random(seed);
        operand_b_data = $random(seed);
        drive_step(r, 0, 1'b1);
        step_cycle();
        c    = 1;
        seen = issue_valid;
        while (!seen && c < timeout) begin
            drive_step(r, c, 1'b0);
            step_cycle();
            c++;
            seen = issue_valid;
        end
        if (seen) begin
            check_flag(seen, r.exp_issue, $sformatf("row %0d issue_valid", n));
            check_count(c, r.exp_lat, $sformatf("row %0d cycles to issue", n));
        end else if (r.exp_issue) begin
            fail_run($sformatf("Row %0d: no issue seen within %0d cycles", n, timeout));
        end
    endtask

    initial begin
        seed                  = 12615;
        reset                 = 1'b0;
        dispatch_valid        = 1'b0;
        ctrl                  = '0;
        pc                    = '0;
        rd_phys               = '0;
        rob_idx               = '0;
        operand_a_tag         = tag_ready;
        operand_a_data        = '0;
        operand_b_tag         = tag_ready;
        operand_b_data        = '0;
        cdb_valid             = '0;
        cdb_data[0]           = '0;
        cdb_data[1]           = '0;
        cdb_data[2]           = '0;
        eager_flush           = 1'b0;
        mispredicted_distance = '0;
        rob_head              = '0;
        issue_ready           = 1'b0;
        m_occ                 = 1'b0;
        m_a_tag               = tag_ready;
        m_b_tag               = tag_ready;
        m_a_data              = '0;
        m_b_data              = '0;
        m_payload             = '0;
        exp_valid             = 1'b0;

        // Columns are A tag, B tag, ROB index, ROB head, CDB0, CDB1, CDB2 strobe masks,
        // issue_ready mask, flush mask, mispredicted distance, issue expected, issue cycle
        table_rows[0] = '{tag_ready, tag_ready, 5'd0, 5'd0,
                          6'b000000, 6'b000000, 6'b000000, 6'b111111, 6'b000000, 6'd0, 1'b1, 1};
        table_rows[1] = '{2'd1, 2'd2, 5'd4, 5'd0,
                          6'b000100, 6'b000010, 6'b001000, 6'b111111, 6'b000000, 6'd0, 1'b1, 4};
        table_rows[2] = '{tag_ready, tag_ready, 5'd6, 5'd0,
                          6'b000000, 6'b000000, 6'b000000, 6'b110000, 6'b000000, 6'd0, 1'b1, 5};
        // ROB index 2 behind head 30 wraps to a distance of 4
        table_rows[3] = '{2'd0, tag_ready, 5'd2, 5'd30,
                          6'b000100, 6'b000000, 6'b000000, 6'b111111, 6'b000010, 6'd3, 1'b0, 0};
        table_rows[4] = '{2'd0, tag_ready, 5'd2, 5'd30,
                          6'b000100, 6'b000000, 6'b000000, 6'b111111, 6'b000010, 6'd4, 1'b1, 3};
        table_rows[5] = '{2'd2, 2'd0, 5'd9, 5'd0,
                          6'b000010, 6'b000010, 6'b000010, 6'b111111, 6'b000000, 6'd0, 1'b1, 2};
        // Direct issue on the cycle right after a stored issue
        table_rows[6] = '{tag_ready, tag_ready, 5'd1, 5'd0,
                          6'b000000, 6'b000000, 6'b000000, 6'b111111, 6'b000000, 6'd0, 1'b1, 1};

        repeat (10) @(posedge clk);
        #1;
        reset = 1'b1;
        check_flag(issue_valid, 1'b0, "issue_valid after reset");
        check_flag(dispatch_ready, 1'b1, "dispatch_ready after reset");

        for (int n = 0; n < num_rows; n++) begin
            run_row(table_rows[n], n);
        end
        drive_step(table_rows[num_rows-1], num_steps, 1'b0);
        step_cycle();

        $display("RESULT: PASS");
        $finish;
    end

endmodule

// ==== hdl/cdb_if.sv ====
`timescale 1ns/100ps

interface cdb_if
    import rs_pkg::*;
#(
    parameter int data_width = 32
) (
    input logic clk
);

    // Per-channel result strobe, one cycle wide, no back-pressure
    logic [num_cdb-1:0] valid;

    // Result word of each channel, meaningful only while its strobe is high
    logic [data_width-1:0] data [num_cdb];

    // Source side, fed from the external CDB ports
    modport driver (
        output valid,
        output data
    );

    // Snooping side, clk is carried along for checks in the readers
    modport monitor (
        input clk,
        input valid,
        input data
    );

endinterface

// ==== hdl/issue_register.sv ====
`timescale 1ns/100ps

module issue_register
    import rs_pkg::*;
#(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  reset,

    input  logic                  direct_issue,
    input  logic                  stored_issue,

    // Direct path sources
    input  rs_payload_t           dispatch_payload,
    input  logic [data_width-1:0] dispatch_a_data,
    input  logic [data_width-1:0] dispatch_b_data,

    // Stored path sources
    input  rs_payload_t           stored_payload,
    input  logic [data_width-1:0] a_resolved,
    input  logic [data_width-1:0] b_resolved,

    output logic                  issue_valid,
    output rs_payload_t           issue_payload,
    output logic [data_width-1:0] issue_data_a,
    output logic [data_width-1:0] issue_data_b
);

    // ====================
    // Output registers
    // ====================

    // One pulse per issue decision
    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= direct_issue || stored_issue;
        end
    end

    // Payload only moves when something issues
    always_ff @(posedge clk) begin
        if (direct_issue) begin
            issue_payload <= dispatch_payload;
            issue_data_a  <= dispatch_a_data;
            issue_data_b  <= dispatch_b_data;
        end else if (stored_issue) begin
            issue_payload <= stored_payload;
            issue_data_a  <= a_resolved;
            issue_data_b  <= b_resolved;
        end
    end

    // ====================
    // Checks
    // ====================

    // The entry empties on a stored issue, so the pulse cannot stretch
    single_pulse_a: assert property (
        @(posedge clk) disable iff (!reset)
        stored_issue |=> !stored_issue
    ) else $error("issue_valid held beyond one cycle for a single issue");

endmodule

// ==== hdl/operand_snoop.sv ====
`timescale 1ns/100ps

module operand_snoop
    import rs_pkg::*;
#(
    parameter int data_width = 32
) (
    input  tag_t                  tag,
    input  logic [data_width-1:0] stored_data,
    cdb_if.monitor                cdb,
    output logic                  ready,
    output logic [data_width-1:0] resolved_data
);

    logic cdb_hit;

    // ====================
    // Channel match
    // ====================

    // The tag names at most one channel, so at most one iteration can hit
    always_comb begin
        cdb_hit       = 1'b0;
        resolved_data = stored_data;
        for (int k = 0; k < num_cdb; k++) begin
            if (tag == tag_t'(k) && cdb.valid[k]) begin
                cdb_hit       = 1'b1;
                resolved_data = cdb.data[k];
            end
        end
    end

    // Available either from storage or from a strobe in this very cycle
    assign ready = (tag == tag_ready) || cdb_hit;

    // ====================
    // Checks
    // ====================

    // A strobed result must carry a defined value for the operand
    cdb_data_known_a: assert property (
        @(posedge cdb.clk)
        cdb_hit |-> !$isunknown(resolved_data)
    ) else $error("CDB strobe hit operand tag %0d with undefined data", tag);

endmodule

// ==== hdl/reservation_station.sv ====
`timescale 1ns/100ps

module reservation_station
    import rs_pkg::*;
#(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  reset,

    // Dispatch
    input  logic                  dispatch_valid,
    output logic                  dispatch_ready,
    input  ctrl_t                 ctrl,
    input  logic [31:0]           pc,
    input  phys_reg_t             rd_phys,
    input  rob_idx_t              rob_idx,
    input  tag_t                  operand_a_tag,
    input  logic [data_width-1:0] operand_a_data,
    input  tag_t                  operand_b_tag,
    input  logic [data_width-1:0] operand_b_data,

    // Result broadcast
    input  logic [num_cdb-1:0]    cdb_valid,
    input  logic [data_width-1:0] cdb_data [num_cdb],

    // Misprediction flush
    input  logic                  eager_flush,
    input  rob_dist_t             mispredicted_distance,
    input  rob_idx_t              rob_head,

    // Functional unit
    input  logic                  issue_ready,
    output logic                  issue_valid,
    output ctrl_t                 issue_ctrl,
    output logic [31:0]           issue_pc,
    output phys_reg_t             issue_rd_phys,
    output logic [data_width-1:0] issue_data_a,
    output logic [data_width-1:0] issue_data_b
);

    rs_payload_t           dispatch_payload;
    rs_payload_t           stored_payload;
    rs_payload_t           issue_payload;
    tag_t                  a_tag;
    tag_t                  b_tag;
    logic [data_width-1:0] a_data;
    logic [data_width-1:0] b_data;
    logic                  a_ready;
    logic                  b_ready;
    logic [data_width-1:0] a_resolved;
    logic [data_width-1:0] b_resolved;
    logic                  stored_issue;
    logic                  direct_issue;

    // ====================
    // CDB bundle
    // ====================

    cdb_if #(.data_width(data_width)) cdb_bus (.clk(clk));

    assign cdb_bus.valid = cdb_valid;
    assign cdb_bus.data  = cdb_data;

    // ====================
    // Payload packing
    // ====================

    assign dispatch_payload = '{ctrl: ctrl, pc: pc, rd_phys: rd_phys, rob_idx: rob_idx};

    assign issue_ctrl    = issue_payload.ctrl;
    assign issue_pc      = issue_payload.pc;
    assign issue_rd_phys = issue_payload.rd_phys;

    // ====================
    // Datapath
    // ====================

    operand_snoop #(.data_width(data_width)) snoop_a_i (
        .tag           (a_tag),
        .stored_data   (a_data),
        .cdb           (cdb_bus),
        .ready         (a_ready),
        .resolved_data (a_resolved)
    );

    operand_snoop #(.data_width(data_width)) snoop_b_i (
        .tag           (b_tag),
        .stored_data   (b_data),
        .cdb           (cdb_bus),
        .ready         (b_ready),
        .resolved_data (b_resolved)
    );

    rs_entry #(.data_width(data_width)) rs_entry_i (
        .clk                   (clk),
        .reset                 (reset),
        .dispatch_valid        (dispatch_valid),
        .dispatch_payload      (dispatch_payload),
        .dispatch_a_tag        (operand_a_tag),
        .dispatch_b_tag        (operand_b_tag),
        .dispatch_a_data       (operand_a_data),
        .dispatch_b_data       (operand_b_data),
        .a_ready               (a_ready),
        .b_ready               (b_ready),
        .a_resolved            (a_resolved),
        .b_resolved            (b_resolved),
        .issue_ready           (issue_ready),
        .eager_flush           (eager_flush),
        .mispredicted_distance (mispredicted_distance),
        .rob_head              (rob_head),
        .occupied              (),
        .dispatch_ready        (dispatch_ready),
        .stored_payload        (stored_payload),
        .a_tag                 (a_tag),
        .b_tag                 (b_tag),
        .a_data                (a_data),
        .b_data                (b_data),
        .stored_issue          (stored_issue),
        .direct_issue          (direct_issue)
    );

    issue_register #(.data_width(data_width)) issue_register_i (
        .clk              (clk),
        .reset            (reset),
        .direct_issue     (direct_issue),
        .stored_issue     (stored_issue),
        .dispatch_payload (dispatch_payload),
        .dispatch_a_data  (operand_a_data),
        .dispatch_b_data  (operand_b_data),
        .stored_payload   (stored_payload),
        .a_resolved       (a_resolved),
        .b_resolved       (b_resolved),
        .issue_valid      (issue_valid),
        .issue_payload    (issue_payload),
        .issue_data_a     (issue_data_a),
        .issue_data_b     (issue_data_b)
    );

endmodule

// ==== hdl/rs_entry.sv ====
`timescale 1ns/100ps

module rs_entry
    import rs_pkg::*;
#(
    parameter int data_width = 32
) (
    input  logic                  clk,
    input  logic                  reset,

    // Dispatch side
    input  logic                  dispatch_valid,
    input  rs_payload_t           dispatch_payload,
    input  tag_t                  dispatch_a_tag,
    input  tag_t                  dispatch_b_tag,
    input  logic [data_width-1:0] dispatch_a_data,
    input  logic [data_width-1:0] dispatch_b_data,

    // Resolution from the two snoopers
    input  logic                  a_ready,
    input  logic                  b_ready,
    input  logic [data_width-1:0] a_resolved,
    input  logic [data_width-1:0] b_resolved,

    input  logic                  issue_ready,

    // Misprediction flush
    input  logic                  eager_flush,
    input  rob_dist_t             mispredicted_distance,
    input  rob_idx_t              rob_head,

    output logic                  occupied,
    output logic                  dispatch_ready,
    output rs_payload_t           stored_payload,
    output tag_t                  a_tag,
    output tag_t                  b_tag,
    output logic [data_width-1:0] a_data,
    output logic [data_width-1:0] b_data,
    output logic                  stored_issue,
    output logic                  direct_issue
);

    logic      accept;
    logic      dispatch_both_ready;
    rob_dist_t stored_distance;
    logic      flush_hit;

    // ====================
    // Issue decisions
    // ====================

    assign dispatch_ready = !occupied;
    assign accept         = dispatch_valid && dispatch_ready;

    assign dispatch_both_ready = (dispatch_a_tag == tag_ready) && (dispatch_b_tag == tag_ready);

    // Fully ready dispatch bypasses storage when the unit can take it
    assign direct_issue = accept && dispatch_both_ready && issue_ready;

    // Age of the stored instruction measured forward from the ROB head
    always_comb begin
        if (stored_payload.rob_idx >= rob_head) begin
            stored_distance = rob_dist_t'(stored_payload.rob_idx - rob_head);
        end else begin
            stored_distance = rob_dist_t'(rob_depth - int'(rob_head)
                                          + int'(stored_payload.rob_idx));
        end
    end

    // Younger than the mispredicting instruction means squashed
    assign flush_hit = occupied && eager_flush && (stored_distance > mispredicted_distance);

    // A flushed entry must never reach the functional unit
    assign stored_issue = occupied && a_ready && b_ready && issue_ready && !flush_hit;

    // ====================
    // Control state
    // ====================

    always_ff @(posedge clk or negedge reset) begin
        if (!reset) begin
            occupied <= 1'b0;
            a_tag    <= tag_ready;
            b_tag    <= tag_ready;
        end else begin
            if (accept) begin
                occupied <= !direct_issue;
                a_tag    <= dispatch_a_tag;
                b_tag    <= dispatch_b_tag;
            end else if (stored_issue || flush_hit) begin
                occupied <= 1'b0;
            end else if (occupied) begin
                // Snooped operands become ready for good
                if (a_ready) begin
                    a_tag <= tag_ready;
                end
                if (b_ready) begin
                    b_tag <= tag_ready;
                end
            end
        end
    end

    // ====================
    // Payload and operands
    // ====================

    // No CDB capture in the dispatch cycle itself
    always_ff @(posedge clk) begin
        if (accept) begin
            stored_payload <= dispatch_payload;
            a_data         <= dispatch_a_data;
            b_data         <= dispatch_b_data;
        end else if (occupied) begin
            // Resolved value equals stored data unless a strobe matched
            a_data <= a_resolved;
            b_data <= b_resolved;
        end
    end

    // ====================
    // Checks
    // ====================

    // An occupied entry keeps its instruction until it empties
    occupied_payload_held_a: assert property (
        @(posedge clk) disable iff (!reset)
        occupied |=> $stable(stored_payload)
    ) else $error("dispatch accepted while entry occupied");

    issue_paths_exclusive_a: assert property (
        @(posedge clk) disable iff (!reset)
        !(stored_issue && direct_issue)
    ) else $error("stored and direct issue in the same cycle");

endmodule

// ==== hdl/rs_pkg.sv ====
package rs_pkg;

    // ====================
    // Operand tags
    // ====================

    // 0..2 name the producing ALU and 3 means the value is present
    typedef logic [1:0] tag_t;

    localparam tag_t tag_ready = 2'd3;

    // Channel k of the CDB carries results tagged k
    localparam int num_cdb = 3;

    // ====================
    // ROB indexing
    // ====================

    localparam int rob_depth = 32;

    typedef logic [4:0] rob_idx_t;

    // One bit wider than the index so a full lap is still representable
    typedef logic [5:0] rob_dist_t;

    // ====================
    // Instruction context
    // ====================

    typedef logic [5:0] phys_reg_t;

    // Control word is handed to the functional unit undecoded
    typedef logic [10:0] ctrl_t;

    typedef struct packed {
        ctrl_t       ctrl;
        logic [31:0] pc;
        phys_reg_t   rd_phys;
        rob_idx_t    rob_idx;
    } rs_payload_t;

endpackage

// ==== run_sim.sh ====
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert -j 0 \
    --top-module tb_reservation_station \
    -f build.f \
    -o sim_tb
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/sim_tb > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qx "RESULT: PASS" "$log"; then
    exit 0
fi

echo "Pass message not found in $log"
exit 1
